/* tb.f */
+incdir+common
+incdir+sim
common/elem_pkg.sv
src/cmd_decode.sv
element/wave_table.sv
element/env_sequencer.sv
element/am_modulator.sv
element/pulse_element.sv
src/element_sum.sv
src/qdrv_top.sv
sim/tb_qdrv.sv

/* Bender.yml */
package:
  name: qdrv_drive

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/elem_pkg.sv
      - src/cmd_decode.sv
      - element/wave_table.sv
      - element/env_sequencer.sv
      - element/am_modulator.sv
      - element/pulse_element.sv
      - src/element_sum.sv
      - src/qdrv_top.sv
      - target: test
        include_dirs:
          - sim
        files:
          - sim/tb_qdrv.sv

/* sim/tb_qdrv_ref.svh */
// testbench reference model: LFSR source, shadow tables and expected element sample
`ifndef TB_QDRV_REF_SVH
`define TB_QDRV_REF_SVH

logic [31:0] lfsr_state = 32'h45e8;

// shadow copies of every envelope and carrier table
logic [31:0] env_tab [`ELEM_N][1 << `ELEM_AW];
logic [31:0] frq_tab [`ELEM_N][1 << `ELEM_AW];

// 32-bit Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// one LFSR step per bit taken
function logic [31:0] take_bits(input int n);
	logic [31:0] r;
	r = '0;
	for (int i = 0; i < n; i++) begin
		lfsr_state = lfsr_next(lfsr_state);
		r = {r[30:0], lfsr_state[0]};
	end
	return r;
endfunction

// envelope times carrier, then amplitude, both parts truncated after >>> 15
function automatic logic [31:0] expect_sample(input int e, input int ei, input int fi,
		input logic signed [15:0] amp, input bit cw);
	logic [31:0]        ew;
	logic [31:0]        fw;
	logic signed [15:0] ex, ey, cx, cy;
	longint             re, im;
	shortint            re16, im16, ox, oy;
	ew = cw ? 32'h7fff_0000 : env_tab[e][ei % (1 << `ELEM_AW)];
	fw = frq_tab[e][fi % (1 << `ELEM_AW)];
	ex = ew[31:16];
	ey = ew[15:0];
	cx = fw[31:16];  // cos
	cy = fw[15:0];   // sin
	re = longint'(ex) * longint'(cx) - longint'(ey) * longint'(cy);
	im = longint'(ex) * longint'(cy) + longint'(ey) * longint'(cx);
	re16 = shortint'(re >>> 15);
	im16 = shortint'(im >>> 15);
	ox = shortint'((longint'(re16) * longint'(amp)) >>> 15);
	oy = shortint'((longint'(im16) * longint'(amp)) >>> 15);
	return {ox, oy};
endfunction

`endif

/* sim/tb_qdrv.sv */
// testbench for the drive-pulse generator: clock, reset, stimulus, checking, watchdog
`timescale 1ns/1ps
`include "elem_params.svh"

module tb_qdrv import elem_pkg::*; ();

	localparam int AW          = `ELEM_AW;
	localparam int TAB_N       = 1 << `ELEM_AW;
	localparam int OFS         = 1 + `ELEM_LAT + `SUM_LAT; // driving edge to first out_valid
	localparam int MAXC        = 16384;
	localparam int LOAD_CYC    = 2 * `ELEM_N * TAB_N + 40;
	localparam int SINGLE_CYC  = 200;
	localparam int DUAL_CYC    = 220;
	localparam int QUAD_CYC    = 240;
	localparam int CW_CYC      = 220;
	localparam int RESTART_CYC = 220;
	localparam int WD_NS       = (LOAD_CYC + SINGLE_CYC + DUAL_CYC + QUAD_CYC + CW_CYC
		+ RESTART_CYC) * 40 + 2000;

	logic      elem;
	logic      arst_n;
	logic      cmd_stb;
	elem_cmd_t cmd;
	tab_wr_t   tab_wr;
	logic      out_valid;
	iq_t       out;
	logic      busy;

	int          cyc;
	int          errors, checks, tests, failed_tests, test_err0;
	bit          expect_idle;
	logic [31:0] exp_smp [`ELEM_N][MAXC];  // expected element sample per output cycle
	bit          exp_on  [`ELEM_N][MAXC];

	`include "tb_qdrv_ref.svh"

	qdrv_top DUT (
		.elem      (elem),
		.arst_n    (arst_n),
		.cmd_stb   (cmd_stb),
		.cmd       (cmd),
		.tab_wr    (tab_wr),
		.out_valid (out_valid),
		.out       (out),
		.busy      (busy)
	);

	initial begin
		elem = 1'b0;
		cyc  = 0;
		forever begin
			#20;
			cyc  = cyc + 1;  // edge number, ready before the edge
			elem = 1'b1;
			#20;
			elem = 1'b0;
		end
	end

	initial begin
		#(WD_NS);
		$display("watchdog expired after %0d ns, the run did not complete", WD_NS);
		$display("Simulation FAILED");
		$finish;
	end

	// output compare, sampled in the middle of the cycle
	always @(negedge elem) begin : compare
		bit          ev;
		logic [15:0] sx, sy;
		ev = 1'b0;
		sx = '0;
		sy = '0;
		if (arst_n && cyc < MAXC) begin
			for (int e = 0; e < `ELEM_N; e++) begin
				if (exp_on[e][cyc]) begin
					ev = 1'b1;
					sx = sx + exp_smp[e][cyc][31:16];  // wraps at 16 bits
					sy = sy + exp_smp[e][cyc][15:0];
				end
			end
			checks++;
			if (out_valid !== ev) begin
				errors++;
				$display("FAIL t=%0t: out_valid at cycle %0d expected %b got %b",
					$time, cyc, ev, out_valid);
			end
			if (out !== {sx, sy}) begin
				errors++;
				$display("FAIL t=%0t: out at cycle %0d expected %h got %h",
					$time, cyc, {sx, sy}, out);
			end
			if (expect_idle && busy !== 1'b0) begin
				errors++;
				$display("busy was high at cycle %0d although no command was sent", cyc);
			end
		end
	end

	task automatic load_tables();
		logic [31:0] w;
		for (int s = 0; s < `ELEM_N; s++)
			for (int f = 0; f < 2; f++)
				for (int a = 0; a < TAB_N; a++) begin
					w = take_bits(32);
					@(posedge elem);
					tab_wr.en      <= 1'b1;
					tab_wr.sel     <= 2'(s);
					tab_wr.is_freq <= 1'(f);
					tab_wr.addr    <= AW'(a);
					tab_wr.data    <= w;
					if (f == 1)
						frq_tab[s][a] = w;
					else
						env_tab[s][a] = w;
				end
		@(posedge elem);
		tab_wr.en <= 1'b0;
	endtask

	// a later command to the same element owns every cycle from its own offset on
	task automatic schedule_cmd(input int e, input int n, input int es, input int len,
			input int fs, input logic signed [15:0] amp);
		int c0;
		c0 = n + OFS;
		for (int c = c0; c < MAXC; c++)
			exp_on[e][c] = 1'b0;
		if (len == 0 && amp != 0) begin
			for (int c = c0; c < MAXC; c++) begin
				exp_on[e][c]  = 1'b1;
				exp_smp[e][c] = expect_sample(e, 0, fs + c - c0, amp, 1'b1);
			end
		end else begin
			for (int k = 0; k < len && c0 + k < MAXC; k++) begin
				exp_on[e][c0 + k]  = 1'b1;
				exp_smp[e][c0 + k] = expect_sample(e, es + k, fs + k, amp, 1'b0);
			end
		end
	endtask

	task automatic send_cmd(input int e, input int es, input int len, input int fs,
			input logic signed [15:0] amp);
		@(posedge elem);
		cmd_stb        <= 1'b1;
		cmd.sel        <= 2'(e);
		cmd.env_start  <= AW'(es);
		cmd.env_length <= AW'(len);
		cmd.freq_start <= AW'(fs);
		cmd.amp        <= amp;
		schedule_cmd(e, cyc, es, len, fs, amp);
		@(posedge elem);
		cmd_stb <= 1'b0;
	endtask

	// pulses are long enough that staggered starts always overlap
	task automatic random_pulse(input int e);
		int                 es, len, fs;
		logic signed [15:0] amp;
		es  = take_bits(AW);
		len = 16 + take_bits(6);
		fs  = take_bits(AW);
		amp = take_bits(16);
		if (amp == 0)
			amp = 16'sh4000;
		send_cmd(e, es, len, fs, amp);
	endtask

	task automatic wait_idle(input int limit);
		int waited;
		bit early;
		bit late;
		waited = 0;
		early  = 1'b0;
		late   = 1'b1;
		@(negedge elem);
		while (busy !== 1'b0 && waited < limit) begin
			@(negedge elem);
			waited++;
		end
		if (busy !== 1'b0) begin
			errors++;
			$display("busy still high after %0d cycles, the DUT did not go idle", limit);
		end else begin
			for (int e = 0; e < `ELEM_N; e++) begin
				if (exp_on[e][cyc - 1])
					late = 1'b0;  // last sample left the summer one cycle ago
				for (int c = cyc; c < MAXC; c++)
					if (exp_on[e][c])
						early = 1'b1;
			end
			if (early) begin
				errors++;
				$display("busy fell at cycle %0d while samples were still due", cyc);
			end else if (late) begin
				errors++;
				$display("busy stayed high after the last sample, it fell at cycle %0d", cyc);
			end
		end
	endtask

	task automatic finish_test(input string name);
		tests++;
		if (errors == test_err0) begin
			$display("test %s: ok", name);
		end else begin
			failed_tests++;
			$display("test %s: %0d errors", name, errors - test_err0);
		end
		test_err0 = errors;
	endtask

	initial begin
		arst_n      = 1'b0;
		cmd_stb     = 1'b0;
		cmd         = '0;
		tab_wr      = '0;
		expect_idle = 1'b1;
		repeat (8) @(posedge elem);
		arst_n <= 1'b1;

		load_tables();
		repeat (4) @(posedge elem);
		expect_idle = 1'b0;
		finish_test("reset_and_load");

		random_pulse(1);
		wait_idle(SINGLE_CYC);
		finish_test("single_pulse");

		random_pulse(0);
		repeat (3) @(posedge elem);
		random_pulse(3);
		wait_idle(DUAL_CYC);
		finish_test("two_elements");

		for (int e = 0; e < `ELEM_N; e++) begin
			random_pulse(e);
			repeat (2) @(posedge elem);
		end
		wait_idle(QUAD_CYC);
		finish_test("four_elements");

		// carrier starts close to the top so the address wraps
		send_cmd(2, 0, 0, TAB_N - 24, 16'sh6000);
		repeat (60) @(posedge elem);
		send_cmd(2, 0, 0, 0, 16'sh0000);
		wait_idle(CW_CYC);
		finish_test("continuous_wave");

		send_cmd(1, 100, 50, 200, 16'sh5000);
		repeat (20) @(posedge elem);
		send_cmd(1, 900, 40, 1010, -16'sh3000);
		wait_idle(RESTART_CYC);
		finish_test("restart");

		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests, failed_tests, checks, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

/* src/qdrv_top.sv */
// drive-pulse generator top: command decoder, drive elements and output summer
`timescale 1ns/1ps
`include "elem_params.svh"

module qdrv_top import elem_pkg::*; (
	input  logic        elem,
	input  logic        arst_n,
	input  logic        cmd_stb,
	input  elem_cmd_t   cmd,
	input  tab_wr_t     tab_wr,
	output logic        out_valid,
	output iq_t         out,
	output logic        busy
);

	logic [`ELEM_N-1:0] start;
	logic [`ELEM_N-1:0] valid_e;
	logic [`ELEM_N-1:0] busy_e;
	elem_cmd_t          cmd_q;
	logic               cw;
	logic               stop;
	iq_t                samples [`ELEM_N];

	cmd_decode u_dec (
		.elem    (elem),
		.arst_n  (arst_n),
		.cmd_stb (cmd_stb),
		.cmd     (cmd),
		.start   (start),
		.cmd_q   (cmd_q),
		.cw      (cw),
		.stop    (stop)
	);

	for (genvar i = 0; i < `ELEM_N; i++) begin : g_elem
		pulse_element #(.IDX(i)) u_elem (
			.elem   (elem),
			.arst_n (arst_n),
			.start  (start[i]),
			.cw     (cw),
			.stop   (stop),
			.cmd    (cmd_q),
			.tab_wr (tab_wr),
			.sample (samples[i]),
			.valid  (valid_e[i]),
			.busy   (busy_e[i])
		);
	end

	element_sum u_sum (
		.elem      (elem),
		.arst_n    (arst_n),
		.samples   (samples),
		.valid_in  (valid_e),
		.busy_in   (busy_e),
		.out       (out),
		.out_valid (out_valid),
		.busy      (busy)
	);

endmodule

/* src/element_sum.sv */
// pairwise adder tree over the element streams with valid and busy merge
`timescale 1ns/1ps
`include "elem_params.svh"

module element_sum import elem_pkg::*; (
	input  logic                elem,
	input  logic                arst_n,
	input  iq_t                 samples [`ELEM_N],
	input  logic [`ELEM_N-1:0]  valid_in,
	input  logic [`ELEM_N-1:0]  busy_in,
	output iq_t                 out,
	output logic                out_valid,
	output logic                busy
);

	localparam int NP = `ELEM_N / 2;

	iq_t                lvl1 [NP];
	iq_t                lvl2;
	logic [`SUM_LAT-1:0] vld_sr;

	// sums wrap at 16 bits
	always_ff @(posedge elem) begin
		for (int i = 0; i < NP; i++) begin
			lvl1[i].x <= samples[2*i].x + samples[2*i+1].x;
			lvl1[i].y <= samples[2*i].y + samples[2*i+1].y;
		end
		lvl2.x <= lvl1[0].x + lvl1[1].x;
		lvl2.y <= lvl1[0].y + lvl1[1].y;
	end

	always_ff @(posedge elem or negedge arst_n) begin
		if (!arst_n) begin
			out    <= '0;
			vld_sr <= '0;
		end else begin
			out    <= lvl2;
			vld_sr <= {vld_sr[`SUM_LAT-2:0], |valid_in};
		end
	end

	assign out_valid = vld_sr[`SUM_LAT-1];
	assign busy      = (|busy_in) | (|vld_sr); // samples still in the tree

	a_valid_source: assert property (
		@(posedge elem) disable iff (!arst_n)
		out_valid |-> $past(|valid_in, `SUM_LAT)
	);

endmodule

/* element/pulse_element.sv */
// one drive element: sequencer, envelope and carrier tables, modulator
`timescale 1ns/1ps
`include "elem_params.svh"

module pulse_element import elem_pkg::*; #(
	parameter int IDX = 0
) (
	input  logic        elem,
	input  logic        arst_n,
	input  logic        start,
	input  logic        cw,
	input  logic        stop,
	input  elem_cmd_t   cmd,
	input  tab_wr_t     tab_wr,
	output iq_t         sample,
	output logic        valid,
	output logic        busy
);

	logic [`ELEM_AW-1:0] env_addr;
	logic [`ELEM_AW-1:0] freq_addr;
	logic signed [15:0]  amp;
	logic                force_env;
	logic                issue;
	logic [31:0]         env_word;
	logic [31:0]         freq_word;
	logic                wr_mine;
	logic                env_we;
	logic                freq_we;

	assign wr_mine = tab_wr.en && (tab_wr.sel == 2'(IDX));
	assign env_we  = wr_mine && !tab_wr.is_freq;
	assign freq_we = wr_mine && tab_wr.is_freq;

	env_sequencer u_seq (
		.elem      (elem),
		.arst_n    (arst_n),
		.start     (start),
		.cw        (cw),
		.stop      (stop),
		.cmd       (cmd),
		.env_addr  (env_addr),
		.freq_addr (freq_addr),
		.amp       (amp),
		.force_env (force_env),
		.issue     (issue),
		.busy      (busy)
	);

	wave_table u_env_tab (
		.elem  (elem),
		.we    (env_we),
		.waddr (tab_wr.addr),
		.wdata (tab_wr.data),
		.raddr (env_addr),
		.rdata (env_word)
	);

	wave_table u_freq_tab (
		.elem  (elem),
		.we    (freq_we),
		.waddr (tab_wr.addr),
		.wdata (tab_wr.data),
		.raddr (freq_addr),
		.rdata (freq_word)
	);

	am_modulator u_mod (
		.elem      (elem),
		.arst_n    (arst_n),
		.issue     (issue),
		.force_env (force_env),
		.amp       (amp),
		.env_word  (env_word),
		.freq_word (freq_word),
		.sample    (sample),
		.valid     (valid)
	);

endmodule

/* element/am_modulator.sv */
// envelope times carrier complex multiply followed by amplitude scaling
`timescale 1ns/1ps

module am_modulator import elem_pkg::*; (
	input  logic                elem,
	input  logic                arst_n,
	input  logic                issue,
	input  logic                force_env,
	input  logic signed [15:0]  amp,
	input  logic [31:0]         env_word,
	input  logic [31:0]         freq_word,
	output iq_t                 sample,
	output logic                valid
);

	localparam logic [31:0] FULL_ENV = 32'h7fff_0000; // full scale on x, zero on y

	logic               issue_q, force_q;
	logic               v0, v1, v2;
	logic signed [15:0] amp_q, amp0, amp1, amp2;
	iq_t                env_r, frq_r;
	logic signed [32:0] re1, im1;
	logic signed [15:0] re2, im2;
	logic signed [31:0] px, py;

	// qualifiers wait for the table read
	always_ff @(posedge elem or negedge arst_n) begin
		if (!arst_n) begin
			issue_q <= 1'b0;
			force_q <= 1'b0;
			v0      <= 1'b0;
			v1      <= 1'b0;
			v2      <= 1'b0;
		end else begin
			issue_q <= issue;
			force_q <= force_env;
			v0      <= issue_q;
			v1      <= v0;
			v2      <= v1;
		end
	end

	always_ff @(posedge elem) begin
		amp_q <= amp;
		env_r <= force_q ? iq_t'(FULL_ENV) : iq_t'(env_word);
		frq_r <= iq_t'(freq_word);  // cos on x, sin on y
		amp0  <= amp_q;
		re1   <= env_r.x * frq_r.x - env_r.y * frq_r.y;
		im1   <= env_r.x * frq_r.y + env_r.y * frq_r.x;
		amp1  <= amp0;
		re2   <= re1[30:15];  // >>> 15, low 16 bits kept
		im2   <= im1[30:15];
		amp2  <= amp1;
	end

	assign px = re2 * amp2;
	assign py = im2 * amp2;

	always_ff @(posedge elem or negedge arst_n) begin
		if (!arst_n) begin
			sample <= '0;
			valid  <= 1'b0;
		end else begin
			sample <= v2 ? {px[30:15], py[30:15]} : '0;  // idle element adds zero
			valid  <= v2;
		end
	end

endmodule

/* element/env_sequencer.sv */
// envelope and carrier address counters, cw state and element busy
`timescale 1ns/1ps
`include "elem_params.svh"

module env_sequencer import elem_pkg::*; (
	input  logic                elem,
	input  logic                arst_n,
	input  logic                start,
	input  logic                cw,
	input  logic                stop,
	input  elem_cmd_t           cmd,
	output logic [`ELEM_AW-1:0] env_addr,
	output logic [`ELEM_AW-1:0] freq_addr,
	output logic signed [15:0]  amp,
	output logic                force_env,
	output logic                issue,
	output logic                busy
);

	// issue to valid at the modulator output
	localparam int TAIL = `ELEM_LAT - 1;

	logic [`ELEM_AW-1:0] remain;
	logic [TAIL-1:0]     tail_sr;

	always_ff @(posedge elem or negedge arst_n) begin
		if (!arst_n) begin
			env_addr  <= '0;
			freq_addr <= '0;
			remain    <= '0;
			issue     <= 1'b0;
			force_env <= 1'b0;
		end else if (start) begin
			// a new command always restarts, the old pulse is dropped
			env_addr  <= cmd.env_start;
			freq_addr <= cmd.freq_start;
			remain    <= cmd.env_length - 1'b1;
			issue     <= !stop;
			force_env <= cw;
		end else if (issue) begin
			env_addr  <= env_addr + 1'b1;
			freq_addr <= freq_addr + 1'b1;  // wraps at table size
			remain    <= remain - 1'b1;
			if (!force_env && remain == '0)
				issue <= 1'b0;
		end
	end

	always_ff @(posedge elem) begin
		if (start)
			amp <= cmd.amp;
	end

	// follows each issued pair down to the modulator output
	always_ff @(posedge elem or negedge arst_n) begin
		if (!arst_n)
			tail_sr <= '0;
		else
			tail_sr <= {tail_sr[TAIL-2:0], issue};
	end

	assign busy = start | issue | (|tail_sr);

	a_issue_needs_start: assert property (
		@(posedge elem) disable iff (!arst_n)
		$rose(issue) |-> $past(start)
	);

endmodule

/* element/wave_table.sv */
// envelope / carrier table, one write port and one registered read port
`timescale 1ns/1ps
`include "elem_params.svh"

module wave_table (
	input  logic                elem,
	input  logic                we,
	input  logic [`ELEM_AW-1:0] waddr,
	input  logic [31:0]         wdata,
	input  logic [`ELEM_AW-1:0] raddr,
	output logic [31:0]         rdata
);

	localparam int DEPTH = 1 << `ELEM_AW;

	logic [31:0] mem [0:DEPTH-1];

	// registered read, maps onto a block RAM
	always_ff @(posedge elem) begin
		if (we)
			mem[waddr] <= wdata;
		rdata <= mem[raddr];
	end

endmodule

/* src/cmd_decode.sv */
// command register, element select decode and pulse / cw / stop classification
`timescale 1ns/1ps
`include "elem_params.svh"

module cmd_decode import elem_pkg::*; (
	input  logic                elem,
	input  logic                arst_n,
	input  logic                cmd_stb,
	input  elem_cmd_t           cmd,
	output logic [`ELEM_N-1:0]  start,
	output elem_cmd_t           cmd_q,
	output logic                cw,
	output logic                stop
);

	localparam logic [`ELEM_N-1:0] SEL_ONE = 1;

	logic no_len;
	logic has_amp;

	assign no_len  = (cmd.env_length == '0);
	assign has_amp = (cmd.amp != '0);

	always_ff @(posedge elem or negedge arst_n) begin
		if (!arst_n) begin
			start <= '0;
			cw    <= 1'b0;
			stop  <= 1'b0;
		end else begin
			start <= cmd_stb ? (SEL_ONE << cmd.sel) : '0;
			cw    <= cmd_stb && no_len && has_amp;
			stop  <= cmd_stb && no_len && !has_amp;
		end
	end

	// command fields are shared by all elements, start picks the one that loads them
	always_ff @(posedge elem) begin
		if (cmd_stb)
			cmd_q <= cmd;
	end

	a_start_onehot: assert property (
		@(posedge elem) disable iff (!arst_n)
		$onehot0(start)
	);

endmodule

/* common/elem_pkg.sv */
// shared types: I/Q sample, element command and table write port
`include "elem_params.svh"

package elem_pkg;

	// one complex sample, x in the upper half of the word
	typedef struct packed {
		logic signed [15:0] x;
		logic signed [15:0] y;
	} iq_t;

	// pulse command to one element
	typedef struct packed {
		logic [1:0]             sel;        // target element
		logic [`ELEM_AW-1:0]    env_start;
		logic [`ELEM_AW-1:0]    env_length; // zero selects cw or stop
		logic [`ELEM_AW-1:0]    freq_start;
		logic signed [15:0]     amp;        // Q1.15
	} elem_cmd_t;

	// write port shared by all envelope and carrier tables
	typedef struct packed {
		logic                   en;
		logic [1:0]             sel;
		logic                   is_freq;    // carrier table when set
		logic [`ELEM_AW-1:0]    addr;
		logic [31:0]            data;       // x upper, y lower
	} tab_wr_t;

endpackage

/* common/elem_params.svh */
// table size, element count and pipeline latencies
`ifndef ELEM_PARAMS_SVH
`define ELEM_PARAMS_SVH

// table address width, 1024 words per envelope and carrier table
`define ELEM_AW 10

// number of drive elements summed into the output
`define ELEM_N 4

// sampled command strobe to first valid element sample
`define ELEM_LAT 6

// element samples to summed output
`define SUM_LAT 3

`endif
